// ==== src.f ====
+incdir+source
source/csr_pkg.sv
source/instr_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
source/csr_file.sv
source/trap_ctrl.sv
source/csr_unit_top.sv
bench/tb_clock.sv
bench/csr_unit_tb.sv

// ==== Makefile ====
TOP := csr_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== bench/csr_unit_tb.sv ====
`include "csr_defines.svh"

module csr_unit_tb;
    import csr_pkg::*;
    import instr_pkg::*;

    localparam int MAX_CYCLES = 4000;
    localparam int ACK_WAIT   = 20;

    logic      clk;
    logic      arst_n;
    logic      req;
    instr_t    instr;
    csr_word_t rs1;
    pc_t       pc;
    logic      irq;
    logic      ack;
    csr_rsp_t  rsp;
    logic      trap;
    pc_t       trap_pc;

    integer    seed = 89305;
    int        n_checks = 0;
    int        n_errors = 0;
    int        cycle_cnt = 0;
    int        release_wait;
    csr_word_t ref_csr [0:4095];  // reference model, indexed by csr address

    tb_clock #(.PERIOD(40)) u_tb_clock (.clk_o(clk));

    csr_unit_top u_csr_unit_top (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .req_i     (req),
        .instr_i   (instr),
        .rs1_i     (rs1),
        .pc_i      (pc),
        .irq_i     (irq),
        .ack_o     (ack),
        .rsp_o     (rsp),
        .trap_o    (trap),
        .trap_pc_o (trap_pc)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic instr_t csr_instr(logic [2:0] f3, csr_addr_t addr, logic [4:0] src);
        return {addr, src, f3, 5'd1, `OPC_SYSTEM};  // rd = x1
    endfunction

    task automatic compare_word(input csr_word_t got, input csr_word_t exp, input string what);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR @%0t: %s got %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic verify_flag(input logic got, input logic exp, input string what);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // full four-phase handshake, req held hold_cycles past the ack
    task automatic transact(input instr_t word, input csr_word_t src_val, input int hold_cycles,
                            output csr_rsp_t result);
        int       waited;
        csr_rsp_t first;
        waited = 0;
        @(posedge clk);
        #1;
        instr = word;
        rs1   = src_val;
        req   = 1'b1;
        while (!ack && waited < ACK_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        n_checks++;
        assert (ack) else begin
            $display("no ack from DUT within %0d cycles for instruction %h", ACK_WAIT, word);
            n_errors++;
        end
        result = rsp;
        first  = rsp;
        repeat (hold_cycles) begin
            @(posedge clk);
            #1;
            verify_flag(ack, 1'b1, "ack during held request");
            compare_word(rsp.rd_data, first.rd_data, "rd_data during held request");
        end
        req          = 1'b0;
        release_wait = 0;
        while (ack && release_wait < ACK_WAIT) begin
            @(posedge clk);
            #1;
            release_wait++;
        end
        n_checks++;
        assert (!ack) else begin
            $display("ack stayed high for %0d cycles after req dropped", ACK_WAIT);
            n_errors++;
        end
    endtask

    // csr instruction checked against the model, model updated after
    task automatic csr_op(input logic [2:0] f3, input csr_addr_t addr, input logic [4:0] src,
                          input csr_word_t src_val);
        csr_rsp_t  result;
        csr_word_t operand;
        csr_word_t old_val;
        logic      writes;
        old_val = ref_csr[addr];
        operand = f3[2] ? {27'd0, src} : src_val;
        writes  = (f3 == `F3_CSRRW) || (src != 5'd0);  // zero source is a pure read
        transact(csr_instr(f3, addr, src), src_val, 0, result);
        compare_word(result.rd_data, old_val, $sformatf("rd of csr %h, funct3 %0d", addr, f3));
        verify_flag(result.illegal, 1'b0, $sformatf("illegal for csr %h", addr));
        if (writes) begin
            case (f3)
                `F3_CSRRS, `F3_CSRRSI: ref_csr[addr] = old_val | operand;
                `F3_CSRRC, `F3_CSRRCI: ref_csr[addr] = old_val & ~operand;
                default:               ref_csr[addr] = operand;
            endcase
        end
    endtask

    task automatic read_back(input csr_addr_t addr);
        csr_word_t junk;
        junk = $random(seed);  // ignored by csrrs with x0
        csr_op(`F3_CSRRS, addr, 5'd0, junk);
    endtask

    task automatic illegal_op(input instr_t word, input string what);
        csr_rsp_t  result;
        csr_word_t src_val;
        src_val = $random(seed);
        transact(word, src_val, 0, result);
        compare_word(result.rd_data, '0, {what, " rd"});
        verify_flag(result.illegal, 1'b1, {what, " illegal"});
    endtask

    task automatic hold_irq_no_trap(input string what);
        @(posedge clk);
        #1;
        irq = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            verify_flag(trap, 1'b0, what);
        end
        irq = 1'b0;
    endtask

    task automatic reset_state();
        verify_flag(ack, 1'b0, "ack after reset");
        verify_flag(trap, 1'b0, "trap after reset");
        read_back(`CSR_MSTATUS);
        read_back(`CSR_MIE);
        read_back(`CSR_MTVEC);
        read_back(`CSR_MSCRATCH);
        read_back(`CSR_MEPC);
        read_back(`CSR_MCAUSE);
    endtask

    task automatic rmw_ops();
        csr_addr_t  addrs [3];
        logic [2:0] ops [6];
        csr_word_t  src_val;
        csr_word_t  rnd;
        logic [4:0] src;
        addrs = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MEPC};
        ops   = '{`F3_CSRRW, `F3_CSRRS, `F3_CSRRC, `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI};
        foreach (addrs[i]) begin
            foreach (ops[j]) begin
                src_val = $random(seed);
                rnd     = $random(seed);
                src     = ops[j][2] ? rnd[4:0] : 5'd5;
                csr_op(ops[j], addrs[i], src, src_val);
                read_back(addrs[i]);
            end
        end
    endtask

    task automatic suppressed_and_illegal();
        instr_t word;
        csr_op(`F3_CSRRW, `CSR_MSCRATCH, 5'd7, 32'h5a5a_0ff0);
        csr_op(`F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        csr_op(`F3_CSRRC, `CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        csr_op(`F3_CSRRWI, `CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        csr_op(`F3_CSRRSI, `CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        csr_op(`F3_CSRRCI, `CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        read_back(`CSR_MSCRATCH);
        illegal_op(csr_instr(`F3_CSRRW, 12'h7c0, 5'd3), "unimplemented csr 7c0");
        word      = csr_instr(`F3_CSRRW, `CSR_MSCRATCH, 5'd3);
        word[6:0] = 7'b011_0011;  // op-reg, not system
        illegal_op(word, "non-system opcode");
        illegal_op(csr_instr(3'b100, `CSR_MSCRATCH, 5'd3), "reserved funct3");
        read_back(`CSR_MSCRATCH);
    endtask

    task automatic cycle_counter();
        csr_rsp_t first;
        csr_rsp_t second;
        csr_rsp_t high;
        transact(csr_instr(`F3_CSRRS, `CSR_CYCLE, 5'd0), '0, 0, first);
        transact(csr_instr(`F3_CSRRS, `CSR_CYCLE, 5'd0), '0, 0, second);
        verify_flag(second.rd_data > first.rd_data, 1'b1, "cycle strictly increasing");
        transact(csr_instr(`F3_CSRRS, `CSR_CYCLEH, 5'd0), '0, 0, high);
        compare_word(high.rd_data, '0, "cycleh early in run");
    endtask

    task automatic irq_taken();
        csr_word_t status;
        int        waited;
        csr_op(`F3_CSRRW, `CSR_MTVEC, 5'd2, 32'h0000_2400);
        csr_op(`F3_CSRRS, `CSR_MIE, 5'd2, 32'h1 << `MIE_MEIE);
        csr_op(`F3_CSRRS, `CSR_MSTATUS, 5'd2, 32'h1 << `MSTATUS_MIE);
        @(posedge clk);
        #1;
        pc     = 32'h8000_0abc;
        irq    = 1'b1;
        waited = 0;
        while (!trap && waited < 10) begin
            @(posedge clk);
            #1;
            waited++;
        end
        n_checks++;
        assert (trap) else begin
            $display("no trap pulse within 10 cycles of raising irq");
            n_errors++;
        end
        compare_word(waited, 3, "cycles from irq to trap pulse");
        compare_word(trap_pc, ref_csr[`CSR_MTVEC], "trap_pc at trap pulse");
        repeat (5) begin
            @(posedge clk);
            #1;
            verify_flag(trap, 1'b0, "trap after the pulse");  // MIE now clear
        end
        irq = 1'b0;
        status                 = ref_csr[`CSR_MSTATUS];
        status[`MSTATUS_MPIE]  = status[`MSTATUS_MIE];
        status[`MSTATUS_MIE]   = 1'b0;
        ref_csr[`CSR_MSTATUS]  = status;
        ref_csr[`CSR_MEPC]     = pc;
        ref_csr[`CSR_MCAUSE]   = `MCAUSE_MEI;
        read_back(`CSR_MEPC);
        read_back(`CSR_MCAUSE);
        read_back(`CSR_MSTATUS);
    endtask

    task automatic irq_masked_and_mret();
        csr_rsp_t  result;
        csr_word_t status;
        hold_irq_no_trap("trap with mstatus.MIE clear");
        transact(`MRET_WORD, '0, 0, result);
        compare_word(result.rd_data, ref_csr[`CSR_MEPC], "mret result");
        verify_flag(result.illegal, 1'b0, "mret illegal");
        status                = ref_csr[`CSR_MSTATUS];
        status[`MSTATUS_MIE]  = status[`MSTATUS_MPIE];
        status[`MSTATUS_MPIE] = 1'b1;
        ref_csr[`CSR_MSTATUS] = status;
        read_back(`CSR_MSTATUS);
        csr_op(`F3_CSRRC, `CSR_MIE, 5'd2, 32'h1 << `MIE_MEIE);
        hold_irq_no_trap("trap with mie.MEIE clear");
    endtask

    task automatic handshake_hold();
        csr_rsp_t  result;
        csr_word_t value;
        value = $random(seed);
        transact(csr_instr(`F3_CSRRW, `CSR_MSCRATCH, 5'd4), value, 10, result);
        compare_word(result.rd_data, ref_csr[`CSR_MSCRATCH], "rd of held csrrw");
        verify_flag(result.illegal, 1'b0, "illegal on held csrrw");
        compare_word(release_wait, 1, "cycles from req drop to ack low");
        ref_csr[`CSR_MSCRATCH] = value;
        read_back(`CSR_MSCRATCH);
    endtask

    initial begin
        arst_n = 1'b0;
        req    = 1'b0;
        instr  = '0;
        rs1    = '0;
        pc     = '0;
        irq    = 1'b0;
        foreach (ref_csr[i]) begin
            ref_csr[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_state();
        rmw_ops();
        suppressed_and_illegal();
        cycle_counter();
        irq_taken();
        irq_masked_and_mret();
        handshake_hold();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// ==== source/csr_unit_top.sv ====
module csr_unit_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  instr_pkg::instr_t   instr_i,
    input  csr_pkg::csr_word_t  rs1_i,
    input  instr_pkg::pc_t      pc_i,
    input  logic                irq_i,
    output logic                ack_o,
    output instr_pkg::csr_rsp_t rsp_o,
    output logic                trap_o,
    output instr_pkg::pc_t      trap_pc_o
);
    import csr_pkg::*;
    import instr_pkg::*;

    csr_dec_t  dec;
    csr_port_t ex_port;
    csr_port_t trap_port;
    csr_word_t ex_rdata;
    csr_word_t mstatus;
    csr_word_t mie;
    csr_word_t mtvec;
    csr_word_t mret_status;
    logic      mret;
    logic      busy;

    csr_decode u_csr_decode (
        .instr_i (instr_i),
        .rs1_i   (rs1_i),
        .dec_o   (dec)
    );

    csr_execute u_csr_execute (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .dec_i         (dec),
        .rd_i          (ex_rdata),
        .mret_status_i (mret_status),
        .port_o        (ex_port),
        .mret_o        (mret),
        .busy_o        (busy),
        .ack_o         (ack_o),
        .rsp_o         (rsp_o)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_port_i    (ex_port),
        .trap_port_i  (trap_port),
        .ex_rdata_o   (ex_rdata),
        .trap_rdata_o (),  // trap side uses the direct taps
        .mstatus_o    (mstatus),
        .mie_o        (mie),
        .mtvec_o      (mtvec)
    );

    trap_ctrl u_trap_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .irq_i         (irq_i),
        .pc_i          (pc_i),
        .busy_i        (busy),
        .mret_i        (mret),
        .mstatus_i     (mstatus),
        .mie_i         (mie),
        .mtvec_i       (mtvec),
        .mret_status_o (mret_status),
        .port_o        (trap_port),
        .trap_o        (trap_o),
        .trap_pc_o     (trap_pc_o)
    );

endmodule

// ==== source/trap_ctrl.sv ====
`include "csr_defines.svh"

module trap_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               irq_i,
    input  instr_pkg::pc_t     pc_i,
    input  logic               busy_i,
    input  logic               mret_i,
    input  csr_pkg::csr_word_t mstatus_i,
    input  csr_pkg::csr_word_t mie_i,
    input  csr_pkg::csr_word_t mtvec_i,
    output csr_pkg::csr_word_t mret_status_o,
    output csr_pkg::csr_port_t port_o,
    output logic               trap_o,
    output instr_pkg::pc_t     trap_pc_o
);
    import csr_pkg::*;
    import instr_pkg::*;

    typedef enum logic [1:0] {T_IDLE, T_CAUSE, T_STATUS} trap_state_e;

    trap_state_e state_q;
    logic        accept;
    csr_word_t   trap_status;
    logic        trap_q;

    // mret writes mstatus this cycle, so hold off
    assign accept = (state_q == T_IDLE) && irq_i && !busy_i && !mret_i
                    && mstatus_i[`MSTATUS_MIE] && mie_i[`MIE_MEIE];

    always_comb begin
        trap_status                = mstatus_i;
        trap_status[`MSTATUS_MPIE] = mstatus_i[`MSTATUS_MIE];
        trap_status[`MSTATUS_MIE]  = 1'b0;

        mret_status_o                = mstatus_i;
        mret_status_o[`MSTATUS_MIE]  = mstatus_i[`MSTATUS_MPIE];
        mret_status_o[`MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        port_o.raddr = `CSR_MSTATUS;
        case (state_q)
            T_CAUSE: begin
                port_o.we    = 1'b1;
                port_o.waddr = `CSR_MCAUSE;
                port_o.wdata = `MCAUSE_MEI;
            end
            T_STATUS: begin
                port_o.we    = 1'b1;
                port_o.waddr = `CSR_MSTATUS;
                port_o.wdata = trap_status;
            end
            default: begin
                port_o.we    = accept;  // mepc lands on the accepting edge
                port_o.waddr = `CSR_MEPC;
                port_o.wdata = pc_i;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= T_IDLE;
            trap_q  <= 1'b0;
        end else begin
            trap_q <= (state_q == T_STATUS);
            case (state_q)
                T_IDLE:  if (accept) state_q <= T_CAUSE;
                T_CAUSE: state_q <= T_STATUS;
                default: state_q <= T_IDLE;
            endcase
        end
    end

    assign trap_o    = trap_q;
    assign trap_pc_o = mtvec_i;  // direct mode only

endmodule

// ==== source/csr_file.sv ====
`include "csr_defines.svh"

module csr_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  csr_pkg::csr_port_t ex_port_i,
    input  csr_pkg::csr_port_t trap_port_i,
    output csr_pkg::csr_word_t ex_rdata_o,
    output csr_pkg::csr_word_t trap_rdata_o,
    output csr_pkg::csr_word_t mstatus_o,
    output csr_pkg::csr_word_t mie_o,
    output csr_pkg::csr_word_t mtvec_o
);
    import csr_pkg::*;

    cycle_t    cycle_q;
    csr_word_t mtvec_q;
    csr_word_t mcause_q;
    csr_word_t mepc_q;
    csr_word_t mie_q;
    csr_word_t mstatus_q;
    csr_word_t mscratch_q;

    // execute port wins a conflict on the same register
    function automatic csr_word_t next_val(csr_addr_t addr, csr_word_t cur);
        csr_word_t val;
        val = cur;
        if (ex_port_i.we && ex_port_i.waddr == addr) begin
            val = ex_port_i.wdata;
        end else if (trap_port_i.we && trap_port_i.waddr == addr) begin
            val = trap_port_i.wdata;
        end
        return val;
    endfunction

    function automatic csr_word_t port_read(csr_port_t port);
        csr_word_t val;
        case (port.raddr)
            `CSR_CYCLE:    val = cycle_q[`CSR_XLEN-1:0];
            `CSR_CYCLEH:   val = cycle_q[2*`CSR_XLEN-1:`CSR_XLEN];
            `CSR_MTVEC:    val = mtvec_q;
            `CSR_MCAUSE:   val = mcause_q;
            `CSR_MEPC:     val = mepc_q;
            `CSR_MIE:      val = mie_q;
            `CSR_MSTATUS:  val = mstatus_q;
            `CSR_MSCRATCH: val = mscratch_q;
            default:       val = '0;
        endcase
        // own write goes straight through
        if (port.we && port.waddr == port.raddr) begin
            val = port.wdata;
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q    <= '0;
            mcause_q   <= '0;
            mepc_q     <= '0;
            mie_q      <= '0;
            mstatus_q  <= '0;
            mscratch_q <= '0;
        end else begin
            mtvec_q    <= next_val(`CSR_MTVEC, mtvec_q);
            mcause_q   <= next_val(`CSR_MCAUSE, mcause_q);
            mepc_q     <= next_val(`CSR_MEPC, mepc_q);
            mie_q      <= next_val(`CSR_MIE, mie_q);
            mstatus_q  <= next_val(`CSR_MSTATUS, mstatus_q);
            mscratch_q <= next_val(`CSR_MSCRATCH, mscratch_q);
        end
    end

    always_comb begin
        ex_rdata_o   = port_read(ex_port_i);
        trap_rdata_o = port_read(trap_port_i);
    end

    // direct taps for the trap logic
    assign mstatus_o = mstatus_q;
    assign mie_o     = mie_q;
    assign mtvec_o   = mtvec_q;

endmodule

// ==== source/csr_execute.sv ====
`include "csr_defines.svh"

module csr_execute (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  instr_pkg::csr_dec_t dec_i,
    input  csr_pkg::csr_word_t  rd_i,
    input  csr_pkg::csr_word_t  mret_status_i,
    output csr_pkg::csr_port_t  port_o,
    output logic                mret_o,
    output logic                busy_o,
    output logic                ack_o,
    output instr_pkg::csr_rsp_t rsp_o
);
    import csr_pkg::*;
    import instr_pkg::*;

    typedef enum logic [1:0] {IDLE, ACK, RELEASE} ex_state_e;

    ex_state_e state_q;
    logic      start;
    logic      is_mret;
    csr_word_t new_val;
    logic      we_q;
    logic      mret_q;
    csr_addr_t waddr_q;
    csr_word_t wdata_q;

    assign start   = (state_q == IDLE) && req_i;
    assign is_mret = dec_i.legal && (dec_i.op == OP_MRET);

    always_comb begin
        case (dec_i.op)
            OP_RS:   new_val = rd_i | dec_i.operand;
            OP_RC:   new_val = rd_i & ~dec_i.operand;
            OP_MRET: new_val = mret_status_i;
            default: new_val = dec_i.operand;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            we_q    <= 1'b0;
            mret_q  <= 1'b0;
        end else begin
            we_q   <= start && dec_i.legal && (dec_i.write_en || is_mret);
            mret_q <= start && is_mret;
            case (state_q)
                IDLE:    if (req_i) state_q <= ACK;
                ACK:     if (!req_i) state_q <= RELEASE;  // requester holds us here
                default: state_q <= IDLE;
            endcase
        end
    end

    // old value and the write, latched at the sampling edge
    always_ff @(posedge clk) begin
        if (start) begin
            waddr_q       <= is_mret ? csr_addr_t'(`CSR_MSTATUS) : dec_i.addr;
            wdata_q       <= new_val;
            rsp_o.rd_data <= dec_i.legal ? rd_i : '0;
            rsp_o.illegal <= !dec_i.legal;
        end
    end

    always_comb begin
        port_o.we    = we_q;
        port_o.waddr = waddr_q;
        port_o.wdata = wdata_q;
        port_o.raddr = dec_i.addr;
    end

    assign mret_o = mret_q;
    assign ack_o  = (state_q == ACK);
    assign busy_o = req_i || (state_q == ACK);

endmodule

// ==== source/csr_decode.sv ====
`include "csr_defines.svh"

module csr_decode (
    input  instr_pkg::instr_t   instr_i,
    input  csr_pkg::csr_word_t  rs1_i,
    output instr_pkg::csr_dec_t dec_o
);
    import csr_pkg::*;
    import instr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_idx;
    csr_addr_t  addr;
    logic       addr_ok;
    logic       f3_ok;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign rs1_idx = instr_i[19:15];  // doubles as zimm
    assign addr    = instr_i[31:20];

    // implemented csrs only
    always_comb begin
        case (addr)
            `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
            `CSR_MEPC, `CSR_MCAUSE, `CSR_CYCLE, `CSR_CYCLEH: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        dec_o         = '0;
        dec_o.op      = OP_RW;
        dec_o.addr    = addr;
        dec_o.operand = funct3[2] ? csr_word_t'(rs1_idx) : rs1_i;
        f3_ok         = 1'b1;

        case (funct3)
            `F3_CSRRW, `F3_CSRRWI: dec_o.op = OP_RW;
            `F3_CSRRS, `F3_CSRRSI: dec_o.op = OP_RS;
            `F3_CSRRC, `F3_CSRRCI: dec_o.op = OP_RC;
            `F3_PRIV: begin
                dec_o.op   = OP_MRET;
                dec_o.addr = `CSR_MEPC;  // mret returns mepc
                f3_ok      = (instr_i == `MRET_WORD);
            end
            default: f3_ok = 1'b0;
        endcase

        // zero source means read only, except plain csrrw
        dec_o.write_en = !(rs1_idx == 5'd0 && (funct3[2] || dec_o.op != OP_RW))
                         && (dec_o.op != OP_MRET);

        dec_o.legal = (opcode == `OPC_SYSTEM) && f3_ok
                      && (dec_o.op == OP_MRET || addr_ok);
    end

endmodule

// ==== source/instr_pkg.sv ====
`include "csr_defines.svh"

package instr_pkg;

    typedef logic [31:0]          instr_t;
    typedef logic [`CSR_XLEN-1:0] pc_t;

    typedef enum logic [1:0] {
        OP_RW,
        OP_RS,
        OP_RC,
        OP_MRET
    } csr_op_e;

    // decoded system instruction
    typedef struct packed {
        csr_op_e            op;
        csr_pkg::csr_addr_t addr;
        csr_pkg::csr_word_t operand;   // rs1 value or zimm
        logic               write_en;
        logic               legal;
    } csr_dec_t;

    // answer to the requester
    typedef struct packed {
        csr_pkg::csr_word_t rd_data;
        logic               illegal;
    } csr_rsp_t;

endpackage

// ==== source/csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

    // csr address and data
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_XLEN-1:0]   csr_word_t;

    // free running counter behind cycle/cycleh
    typedef logic [2*`CSR_XLEN-1:0] cycle_t;

    // one access port of the csr file
    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        csr_word_t wdata;
        csr_addr_t raddr;
    } csr_port_t;

endpackage

// ==== source/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// machine mode csr addresses
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_CYCLE    12'hc00
`define CSR_CYCLEH   12'hc80

`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MIE_MEIE     11

`define MCAUSE_MEI 32'h8000_000b  // interrupt bit, cause 11

`define OPC_SYSTEM 7'b111_0011
`define F3_PRIV    3'b000
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010
`define F3_CSRRC   3'b011
`define F3_CSRRWI  3'b101
`define F3_CSRRSI  3'b110
`define F3_CSRRCI  3'b111
`define MRET_WORD  32'h3020_0073

`endif
